// File: dbg_monitor_top.f
dbg_pkg.sv
uart_rx.sv
dbg_cmd_engine.sv
dbg_mem.sv
uart_tx.sv
dbg_monitor_top.sv
tb_dbg_monitor.sv

// File: Bender.yml
package:
  name: dbg_monitor

sources:
  - dbg_pkg.sv
  - uart_rx.sv
  - dbg_cmd_engine.sv
  - dbg_mem.sv
  - uart_tx.sv
  - dbg_monitor_top.sv
  - target: test
    files:
      - tb_dbg_monitor.sv

// File: tb_dbg_monitor.sv
`timescale 1ns/100ps
/* debug monitor testbench
   plays the host on the serial line and checks replies, ram contents and status */
module tb_dbg_monitor;
    localparam int CPB           = 8;
    localparam int DRIVE_DLY     = 10;        // ns after the rising edge
    localparam int START_TIMEOUT = 40 * CPB;  // cycles to wait for a reply frame
    localparam int QUIET_WINDOW  = 20 * CPB;

    logic            clk;
    logic            reset_n;
    logic            uart_rx;
    logic            uart_tx;
    dbg_pkg::cmd_e   cmd;
    dbg_pkg::count_t remaining;

    dbg_pkg::byte_t  ram_model [256];  // mirrors the 8 bit decoded ram
    logic [15:0]     lfsr_q;
    int              mismatches;
    int              failures;

    dbg_monitor_top #(.CLKS_PER_BIT(CPB), .MEM_ADDR_BITS(8)) dut_i (
        .i_clk                 (clk),
        .i_reset_n             (reset_n),
        .i_uart_rx             (uart_rx),
        .o_uart_tx             (uart_tx),
        .o_cmd                 (cmd),
        .o_cmd_bytes_remaining (remaining)
    );

    always #50 clk = ~clk;

    task automatic wait_drive_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic settle();
        repeat (2) wait_drive_slot();
    endtask

    // galois form with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic random_byte(output dbg_pkg::byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            b      = {b[6:0], lfsr_q[0]};
        end
    endtask

    task automatic check_byte(input string name, input dbg_pkg::byte_t got,
                              input dbg_pkg::byte_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_cmd(input string name, input dbg_pkg::cmd_e got,
                             input dbg_pkg::cmd_e exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input dbg_pkg::count_t got,
                               input dbg_pkg::count_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_status(input dbg_pkg::cmd_e exp_cmd, input dbg_pkg::count_t exp_rem);
        check_cmd("o_cmd", cmd, exp_cmd);
        check_count("o_cmd_bytes_remaining", remaining, exp_rem);
    endtask

    // one 8n1 frame lsb first with each bit held for CPB cycles
    task automatic send_byte(input dbg_pkg::byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            wait_drive_slot();
            uart_rx = frame[i];
            repeat (CPB - 1) @(posedge clk);
        end
        wait_drive_slot();  // end of stop bit
    endtask

    task automatic recv_byte(output dbg_pkg::byte_t b, output logic ok);
        int waited;
        waited = 0;
        b      = '0;
        ok     = 1'b0;
        @(negedge clk);
        while (uart_tx !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (uart_tx !== 1'b0) begin
            failures++;
            $display("timeout: no start bit on o_uart_tx within %0d cycles", START_TIMEOUT);
        end else begin
            repeat (CPB / 2) @(negedge clk);  // middle of the start bit
            for (int i = 0; i < 8; i++) begin
                repeat (CPB) @(negedge clk);
                b[i] = uart_tx;
            end
            repeat (CPB) @(negedge clk);
            if (uart_tx !== 1'b1) begin
                failures++;
                $display("stop bit on o_uart_tx was low");
            end
            ok = 1'b1;
        end
    endtask

    task automatic expect_line_idle(input int cycles);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < cycles && !seen; i++) begin
            @(negedge clk);
            seen = (uart_tx !== 1'b1);
        end
        if (seen) begin
            failures++;
            $display("o_uart_tx left idle when no reply was due");
        end
        wait_drive_slot();
    endtask

    // remaining after n header bytes as each count byte adds its weight
    function automatic dbg_pkg::count_t header_remaining(input int n,
                                                         input dbg_pkg::count_t count);
        dbg_pkg::count_t r;
        r = dbg_pkg::count_t'(4 - n);
        if (n >= 3) begin
            r = r + {count[15:8], 8'h00};
        end
        if (n >= 4) begin
            r = r + {8'h00, count[7:0]};
        end
        return r;
    endfunction

    task automatic send_header(input dbg_pkg::cmd_e code, input dbg_pkg::addr_t addr,
                               input dbg_pkg::count_t count);
        dbg_pkg::byte_t hdr [4];
        hdr[0] = addr[15:8];
        hdr[1] = addr[7:0];
        hdr[2] = count[15:8];
        hdr[3] = count[7:0];
        send_byte(code);
        settle();
        check_status(code, 16'd4);
        for (int n = 1; n <= 4; n++) begin
            send_byte(hdr[n-1]);
            settle();
            check_count("o_cmd_bytes_remaining", remaining, header_remaining(n, count));
        end
    endtask

    task automatic write_random(input dbg_pkg::addr_t addr, input int count);
        dbg_pkg::byte_t v;
        dbg_pkg::addr_t a;
        send_header(dbg_pkg::CMD_MEM_WRITE, addr, dbg_pkg::count_t'(count));
        for (int i = 0; i < count; i++) begin
            random_byte(v);
            send_byte(v);
            a = addr + dbg_pkg::addr_t'(i);
            ram_model[a[7:0]] = v;  // only the low address bits decode
        end
        settle();
        check_status(dbg_pkg::CMD_NOP, '0);
    endtask

    task automatic read_check(input dbg_pkg::addr_t addr, input int count);
        dbg_pkg::byte_t got;
        dbg_pkg::addr_t a;
        logic           ok;
        send_header(dbg_pkg::CMD_MEM_READ, addr, dbg_pkg::count_t'(count));
        for (int i = 0; i < count; i++) begin
            send_byte(8'hFF);  // filler paces each reply
            recv_byte(got, ok);
            a = addr + dbg_pkg::addr_t'(i);
            if (ok) begin
                check_byte("o_uart_tx", got, ram_model[a[7:0]]);
            end
        end
        settle();
        check_status(dbg_pkg::CMD_NOP, '0);
    endtask

    task automatic test_reset();
        expect_line_idle(4 * CPB);
        check_status(dbg_pkg::CMD_NOP, '0);
    endtask

    task automatic test_echo(input int reps);
        dbg_pkg::byte_t v;
        dbg_pkg::byte_t got;
        logic           ok;
        for (int r = 0; r < reps; r++) begin
            random_byte(v);
            send_byte(dbg_pkg::CMD_ECHO);
            send_byte(v);
            recv_byte(got, ok);
            if (ok) begin
                check_byte("o_uart_tx", got, v);
            end
            settle();
            check_status(dbg_pkg::CMD_NOP, '0);
        end
    endtask

    task automatic test_nop_codes();
        dbg_pkg::byte_t codes [3];
        codes[0] = dbg_pkg::CMD_NOP;
        codes[1] = 8'h7F;
        codes[2] = 8'hFF;
        for (int i = 0; i < 3; i++) begin
            send_byte(codes[i]);
            expect_line_idle(QUIET_WINDOW);
            check_status(dbg_pkg::CMD_NOP, '0);
        end
        test_echo(1);
    endtask

    task automatic test_write_read();
        write_random(16'h0040, 6);
        read_check(16'h003E, 10);  // two untouched bytes on each side
    endtask

    task automatic test_wrap();
        write_random(16'h00FD, 5);
        read_check(16'h00FB, 9);
        send_header(dbg_pkg::CMD_MEM_READ, 16'h0010, '0);  // empty read
        expect_line_idle(QUIET_WINDOW);
        check_status(dbg_pkg::CMD_NOP, '0);
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        uart_rx    = 1'b1;
        lfsr_q     = 16'd76;
        mismatches = 0;
        failures   = 0;
        for (int i = 0; i < 256; i++) begin
            ram_model[i] = '0;  // ram clears at reset
        end
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        reset_n = 1'b1;

        test_reset();
        test_echo(4);
        test_nop_codes();
        test_write_read();
        test_wrap();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: dbg_monitor_top.sv
`timescale 1ns/100ps
/* uart debug monitor top
   receiver, command engine, local ram and transmitter in a chain */
module dbg_monitor_top #(
    parameter int CLKS_PER_BIT  = 16,
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_uart_rx,
    output logic            o_uart_tx,
    output dbg_pkg::cmd_e   o_cmd,
    output dbg_pkg::count_t o_cmd_bytes_remaining
);
    logic            rx_dv;
    dbg_pkg::byte_t  rx_byte;
    logic            tx_dv;
    dbg_pkg::byte_t  tx_byte;
    logic            tx_busy;
    logic            mem_en;
    logic            mem_rw;
    dbg_pkg::addr_t  mem_addr;
    dbg_pkg::byte_t  mem_wdata;
    dbg_pkg::byte_t  mem_rdata;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_rx      (i_uart_rx),
        .o_rx_dv   (rx_dv),
        .o_rx_byte (rx_byte)
    );

    dbg_cmd_engine engine_i (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_rx_dv               (rx_dv),
        .i_rx_byte             (rx_byte),
        .o_tx_dv               (tx_dv),
        .o_tx_byte             (tx_byte),
        .i_tx_busy             (tx_busy),
        .o_mem_addr            (mem_addr),
        .o_mem_rw              (mem_rw),
        .o_mem_en              (mem_en),
        .o_mem_wdata           (mem_wdata),
        .i_mem_rdata           (mem_rdata),
        .o_cmd                 (o_cmd),
        .o_cmd_bytes_remaining (o_cmd_bytes_remaining)
    );

    dbg_mem #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) mem_i (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_en      (mem_en),
        .i_rw      (mem_rw),
        .i_addr    (mem_addr),
        .i_wdata   (mem_wdata),
        .o_rdata   (mem_rdata)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_tx_dv   (tx_dv),
        .i_tx_byte (tx_byte),
        .o_tx      (o_uart_tx),
        .o_tx_busy (tx_busy)
    );

endmodule

// File: uart_tx.sv
`timescale 1ns/100ps
/* uart transmitter
   sends one 8n1 frame per strobe, busy for the whole frame */
module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic           i_clk,
    input  logic           i_reset_n,
    input  logic           i_tx_dv,
    input  dbg_pkg::byte_t i_tx_byte,
    output logic           o_tx,
    output logic           o_tx_busy
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

    dbg_pkg::uart_state_e state_q;
    logic [CNT_W-1:0]     cnt_q;
    logic [2:0]           bit_q;
    dbg_pkg::byte_t       shift_q;
    logic                 tx_q;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state_q <= dbg_pkg::IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            shift_q <= '0;
            tx_q    <= 1'b1;
        end else begin
            if (state_q == dbg_pkg::IDLE) begin
                cnt_q <= '0;
                bit_q <= '0;
                if (i_tx_dv) begin
                    shift_q <= i_tx_byte;
                    tx_q    <= 1'b0;  // start bit
                    state_q <= dbg_pkg::START;
                end
            end else if (cnt_q != BIT_END) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
                case (state_q)
                    dbg_pkg::START: begin
                        tx_q    <= shift_q[0];
                        state_q <= dbg_pkg::DATA;
                    end
                    dbg_pkg::DATA: begin
                        bit_q   <= bit_q + 3'd1;
                        shift_q <= shift_q >> 1;
                        if (bit_q == 3'd7) begin
                            tx_q    <= 1'b1;  // stop bit
                            state_q <= dbg_pkg::STOP;
                        end else begin
                            tx_q <= shift_q[1];
                        end
                    end
                    default: state_q <= dbg_pkg::IDLE;  // end of stop bit
                endcase
            end
        end
    end

    assign o_tx      = tx_q;
    assign o_tx_busy = (state_q != dbg_pkg::IDLE);

endmodule

// File: dbg_mem.sv
`timescale 1ns/100ps
/* local debug ram
   byte wide, registered write and combinational read */
module dbg_mem #(
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic           i_clk,
    input  logic           i_reset_n,
    input  logic           i_en,
    input  logic           i_rw,
    input  dbg_pkg::addr_t i_addr,
    input  dbg_pkg::byte_t i_wdata,
    output dbg_pkg::byte_t o_rdata
);
    localparam int DEPTH = 2 ** MEM_ADDR_BITS;

    dbg_pkg::byte_t           mem_q [DEPTH];
    logic [MEM_ADDR_BITS-1:0] idx;  // upper address bits dropped, so it wraps

    assign idx = i_addr[MEM_ADDR_BITS-1:0];

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (i_en && i_rw == dbg_pkg::RW_WRITE) begin
            mem_q[idx] <= i_wdata;
        end
    end

    assign o_rdata = mem_q[idx];

endmodule

// File: dbg_cmd_engine.sv
`timescale 1ns/100ps
/* debug command engine
   decodes host bytes into echo, ram write and ram read actions */
module dbg_cmd_engine (
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_rx_dv,
    input  dbg_pkg::byte_t  i_rx_byte,
    output logic            o_tx_dv,
    output dbg_pkg::byte_t  o_tx_byte,
    input  logic            i_tx_busy,
    output dbg_pkg::addr_t  o_mem_addr,
    output logic            o_mem_rw,
    output logic            o_mem_en,
    output dbg_pkg::byte_t  o_mem_wdata,
    input  dbg_pkg::byte_t  i_mem_rdata,
    output dbg_pkg::cmd_e   o_cmd,
    output dbg_pkg::count_t o_cmd_bytes_remaining
);
    localparam logic [2:0] HDR_DONE = 3'd4;  // byte index of first payload byte

    dbg_pkg::cmd_e   cmd_q;
    dbg_pkg::count_t remaining_q;
    logic [2:0]      idx_q;    // saturates at HDR_DONE
    logic            rx_dv_q;  // second cycle of a byte
    logic            data_q;   // that byte was payload
    logic            tx_dv_q;
    dbg_pkg::byte_t  tx_byte_q;
    dbg_pkg::addr_t  addr_q;
    logic            mem_rw_q;
    logic            mem_en_q;
    dbg_pkg::byte_t  wdata_q;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            cmd_q       <= dbg_pkg::CMD_NOP;
            remaining_q <= '0;
            idx_q       <= '0;
            rx_dv_q     <= 1'b0;
            data_q      <= 1'b0;
            tx_dv_q     <= 1'b0;
            tx_byte_q   <= '0;
            addr_q      <= '0;
            mem_rw_q    <= dbg_pkg::RW_READ;
            mem_en_q    <= 1'b0;
            wdata_q     <= '0;
        end else begin
            tx_dv_q <= 1'b0;
            rx_dv_q <= i_rx_dv;
            data_q  <= 1'b0;

            if (i_rx_dv) begin
                if (remaining_q == '0) begin
                    // new command
                    idx_q <= '0;
                    case (i_rx_byte)
                        dbg_pkg::CMD_ECHO: begin
                            cmd_q       <= dbg_pkg::CMD_ECHO;
                            remaining_q <= 16'd2;  // value in, value out
                        end
                        dbg_pkg::CMD_MEM_WRITE,
                        dbg_pkg::CMD_MEM_READ: begin
                            cmd_q       <= dbg_pkg::cmd_e'(i_rx_byte);
                            remaining_q <= 16'd4;  // header, count added later
                        end
                        default: begin
                            cmd_q       <= dbg_pkg::CMD_NOP;
                            remaining_q <= '0;
                        end
                    endcase
                end else begin
                    remaining_q <= remaining_q - 16'd1;
                    if (idx_q != HDR_DONE) begin
                        idx_q <= idx_q + 3'd1;
                    end
                    case (cmd_q)
                        dbg_pkg::CMD_ECHO: begin
                            tx_byte_q <= i_rx_byte;
                            data_q    <= 1'b1;
                        end
                        dbg_pkg::CMD_MEM_WRITE,
                        dbg_pkg::CMD_MEM_READ: begin
                            case (idx_q)
                                3'd0: addr_q[15:8] <= i_rx_byte;
                                3'd1: addr_q[7:0]  <= i_rx_byte;
                                3'd2: remaining_q <= remaining_q + {i_rx_byte, 8'h00} - 16'd1;
                                3'd3: remaining_q <= remaining_q + {8'h00, i_rx_byte} - 16'd1;
                                default: begin
                                    // payload byte, one ram access
                                    mem_en_q <= 1'b1;
                                    mem_rw_q <= (cmd_q == dbg_pkg::CMD_MEM_WRITE) ?
                                                dbg_pkg::RW_WRITE : dbg_pkg::RW_READ;
                                    wdata_q  <= i_rx_byte;
                                    data_q   <= 1'b1;
                                end
                            endcase
                        end
                        default: begin
                        end
                    endcase
                end
            end else if (rx_dv_q) begin
                mem_en_q <= 1'b0;
                mem_rw_q <= dbg_pkg::RW_READ;
                if (remaining_q == '0) begin
                    cmd_q <= dbg_pkg::CMD_NOP;
                end
                if (data_q) begin
                    case (cmd_q)
                        dbg_pkg::CMD_ECHO: begin
                            // the reply counts as the last byte
                            tx_dv_q     <= 1'b1;
                            remaining_q <= '0;
                            cmd_q       <= dbg_pkg::CMD_NOP;
                        end
                        dbg_pkg::CMD_MEM_WRITE: addr_q <= addr_q + 16'd1;
                        dbg_pkg::CMD_MEM_READ: begin
                            tx_byte_q <= i_mem_rdata;  // ram answers this cycle
                            tx_dv_q   <= 1'b1;
                            addr_q    <= addr_q + 16'd1;
                        end
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    assign o_cmd                 = cmd_q;
    assign o_cmd_bytes_remaining = remaining_q;
    assign o_tx_dv     = tx_dv_q;
    assign o_tx_byte   = tx_dv_q ? tx_byte_q : '0;
    assign o_mem_en    = mem_en_q;
    assign o_mem_rw    = mem_rw_q;
    assign o_mem_addr  = mem_en_q ? addr_q : '0;
    assign o_mem_wdata = (mem_en_q && mem_rw_q == dbg_pkg::RW_WRITE) ? wdata_q : '0;

    // host pacing must leave the transmitter idle for every reply
    a_tx_not_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(o_tx_dv && i_tx_busy));

    // one ram access per received byte
    a_mem_en_single: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_mem_en |=> !o_mem_en);

endmodule

// File: uart_rx.sv
`timescale 1ns/100ps
/* uart receiver
   oversamples the serial line and strobes out each good byte */
module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic           i_clk,
    input  logic           i_reset_n,
    input  logic           i_rx,
    output logic           o_rx_dv,
    output dbg_pkg::byte_t o_rx_byte
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);

    logic [1:0]           rx_sync_q;  // two flops on the async line
    dbg_pkg::uart_state_e state_q;
    logic [CNT_W-1:0]     cnt_q;
    logic [2:0]           bit_q;
    dbg_pkg::byte_t       shift_q;
    logic                 rx_dv_q;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            rx_sync_q <= 2'b11;  // line idles high
            state_q   <= dbg_pkg::IDLE;
            cnt_q     <= '0;
            bit_q     <= '0;
            shift_q   <= '0;
            rx_dv_q   <= 1'b0;
        end else begin
            rx_sync_q <= {rx_sync_q[0], i_rx};
            rx_dv_q   <= 1'b0;
            case (state_q)
                dbg_pkg::IDLE: begin
                    cnt_q <= '0;
                    if (!rx_sync_q[1]) begin
                        state_q <= dbg_pkg::START;
                    end
                end
                dbg_pkg::START: begin
                    if (cnt_q == HALF_BIT) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        // still low at mid start bit, else just a glitch
                        state_q <= rx_sync_q[1] ? dbg_pkg::IDLE : dbg_pkg::DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                dbg_pkg::DATA: begin
                    if (cnt_q == BIT_END) begin
                        cnt_q   <= '0;
                        shift_q <= {rx_sync_q[1], shift_q[7:1]};  // lsb first
                        bit_q   <= bit_q + 3'd1;
                        if (bit_q == 3'd7) begin
                            state_q <= dbg_pkg::STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                dbg_pkg::STOP: begin
                    if (cnt_q == BIT_END) begin
                        cnt_q   <= '0;
                        rx_dv_q <= rx_sync_q[1];  // low stop bit drops the byte
                        state_q <= dbg_pkg::IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= dbg_pkg::IDLE;
            endcase
        end
    end

    assign o_rx_dv   = rx_dv_q;
    assign o_rx_byte = shift_q;

endmodule

// File: dbg_pkg.sv
/* debug monitor shared types
   byte, address and count widths, command codes and uart states */
package dbg_pkg;

    typedef logic [7:0]  byte_t;   // serial, command and ram data
    typedef logic [15:0] addr_t;   // host side ram address
    typedef logic [15:0] count_t;  // command byte counts

    // host command codes, anything else decodes as nop
    typedef enum logic [7:0] {
        CMD_NOP       = 8'd0,  // code only
        CMD_ECHO      = 8'd1,  // code, value in, value out
        CMD_MEM_WRITE = 8'd2,  // code, addr hi/lo, count hi/lo, data
        CMD_MEM_READ  = 8'd3   // code, addr hi/lo, count hi/lo, fillers
    } cmd_e;

    // level of the ram read/write line
    localparam logic RW_READ  = 1'b1;
    localparam logic RW_WRITE = 1'b0;

    // frame phases for both uart directions
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        START = 2'd1,
        DATA  = 2'd2,
        STOP  = 2'd3
    } uart_state_e;

endpackage
